//--- dv/rom_mux_tb.sv
/*
 * testbench for the ROM access multiplexer
 * miss, hit, priority, offset and download checks against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

module rom_mux_tb;

    localparam int         NUM_SLOTS   = 4;
    localparam logic [3:0] WIDE_MAP    = 4'b1010;  // slots 1 and 3 are 16-bit
    localparam int         N_MISS      = 8;
    localparam int         N_READS     = N_MISS * NUM_SLOTS + 3 * NUM_SLOTS + 8;
    localparam int         CYCLE_LIMIT = N_READS * 30 + 500;

    logic                                          clk;
    logic                                          rst_n;
    logic                                          downloading;
    logic                                          vblank;
    rom_cfg_pkg::cfg_wr_t                          cfg_wr;
    logic [NUM_SLOTS-1:0]                          slot_cs;
    logic [NUM_SLOTS-1:0][15:0]                    slot_addr;
    logic                                          sdram_ack;
    logic                                          data_rdy;
    logic [31:0]                                   data_read;
    rom_cfg_pkg::slot_rd_t [NUM_SLOTS-1:0]         slot_rd;
    sdram_pkg::sdram_cmd_t                         sdram_cmd;
    logic                                          refresh_en;
    logic                                          ready;

    logic [NUM_SLOTS-1:0][21:0] offs;          // offsets as the testbench wrote them
    logic [NUM_SLOTS-1:0][15:0] exp_q;
    logic [NUM_SLOTS-1:0]       exp_valid;
    logic [21:0]                cmd_log[$];
    logic                       cmd_req_q;
    int                         cmd_count;
    int                         errors;
    int                         ok_checks;
    int                         cycles;
    int                         last_wait;
    int                         last_cmds;
    logic [31:0]                rnd;

    rom_mux_top #(
        .NUM_SLOTS ( NUM_SLOTS ),
        .SLOT_AW   ( 16        ),
        .SLOT_WIDE ( WIDE_MAP  )
    ) i_dut (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .vblank      ( vblank      ),
        .cfg_wr      ( cfg_wr      ),
        .slot_cs     ( slot_cs     ),
        .slot_addr   ( slot_addr   ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .slot_rd     ( slot_rd     ),
        .sdram_cmd   ( sdram_cmd   ),
        .refresh_en  ( refresh_en  ),
        .ready       ( ready       )
    );

    sdram_model u_sdram (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cmd       ( sdram_cmd ),
        .sdram_ack ( sdram_ack ),
        .data_rdy  ( data_rdy  ),
        .data_read ( data_read )
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [21:0] translate(logic [21:0] off, logic [15:0] a, logic wide);
        logic [21:0] ext;
        ext = {6'd0, a};
        return off + (wide ? (ext >> 1) : (ext >> 2));
    endfunction

    // expected client data from the SDRAM pattern and the lane rule
    function automatic logic [15:0] expected_data(logic [21:0] off, logic [15:0] a, logic wide);
        logic [21:0] w;
        logic [31:0] word;
        w    = translate(off, a, wide);
        word = {w[15:0] ^ 16'hA5C3, ~w[15:0]};
        if (wide) begin
            return a[0] ? word[31:16] : word[15:0];
        end
        return {8'h00, word[8*a[1:0] +: 8]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // cycle limit against a hung handshake
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // ok at this edge belongs to the cs/addr sampled one edge earlier
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_valid <= '0;
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (slot_rd[i].ok && !exp_valid[i]) begin
                    errors = errors + 1;
                    $display("slot %0d raised ok without being selected", i);
                end else if (slot_rd[i].ok) begin
                    check_value($sformatf("slot_rd[%0d].data", i),
                                32'(slot_rd[i].data), 32'(exp_q[i]));
                    ok_checks = ok_checks + 1;
                end
                exp_q[i] <= expected_data(offs[i], slot_addr[i], WIDE_MAP[i]);
            end
            exp_valid <= slot_cs;
        end
    end

    // log every new SDRAM command
    always @(posedge clk) begin
        if (rst_n && sdram_cmd.req && !cmd_req_q) begin
            cmd_log.push_back(sdram_cmd.addr);
            cmd_count = cmd_count + 1;
        end
        cmd_req_q <= sdram_cmd.req;
    end

    task automatic read_slot(input int s, input logic [15:0] a);
        int n0;
        n0 = cmd_count;
        slot_cs[s]   <= 1'b1;
        slot_addr[s] <= a;
        last_wait = 1;
        @(posedge clk);
        while (!slot_rd[s].ok) begin
            last_wait = last_wait + 1;
            @(posedge clk);
        end
        last_cmds = cmd_count - n0;
        slot_cs[s] <= 1'b0;
        @(posedge clk);
    endtask

    task automatic write_offset(input int s, input logic [21:0] off);
        cfg_wr.we     <= 1'b1;
        cfg_wr.slot   <= 2'(s);
        cfg_wr.offset <= off;
        offs[s]       <= off;
        @(posedge clk);
        cfg_wr.we <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        logic [NUM_SLOTS-1:0][15:0] pa;
        logic [NUM_SLOTS-1:0]       done;
        logic [15:0]                a;
        int                         n;
        int                         base;
        rst_n       = 1'b0;
        downloading = 1'b0;
        vblank      = 1'b0;
        cfg_wr      = '0;
        slot_cs     = '0;
        slot_addr   = '0;
        offs        = '0;
        exp_q       = '0;
        cmd_req_q   = 1'b0;
        cmd_count   = 0;
        errors      = 0;
        ok_checks   = 0;
        cycles      = 0;
        rnd         = 32'd8;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        while (!ready) @(posedge clk);

        // misses on random addresses
        for (int r = 0; r < N_MISS; r++) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                rnd = xorshift32(rnd);
                read_slot(s, rnd[15:0]);
            end
        end

        // other lane of the word just fetched
        for (int s = 0; s < NUM_SLOTS; s++) begin
            rnd = xorshift32(rnd);
            read_slot(s, rnd[15:0]);
            a = WIDE_MAP[s] ? (rnd[15:0] ^ 16'h0001) : (rnd[15:0] ^ 16'h0002);
            read_slot(s, a);
            pa[s] = a;  // word now cached in slot s
            check_value("hit ok latency", 32'(last_wait), 32'd2);
            check_value("sdram_cmd.req count on hit", 32'(last_cmds), 32'd0);
        end

        // all slots miss together and are served 0 to 3
        for (int s = 0; s < NUM_SLOTS; s++) begin
            rnd = xorshift32(rnd);
            a   = {rnd[15:12] ^ 4'(s) ^ 4'h8, rnd[11:0]};
            // steer clear of the word each slot still holds
            pa[s] = (translate(offs[s], a, WIDE_MAP[s])
                     == translate(offs[s], pa[s], WIDE_MAP[s])) ? a ^ 16'h0100 : a;
        end
        base      = cmd_log.size();
        done      = '0;
        slot_cs   <= '1;
        slot_addr <= pa;
        while (done != '1) begin
            @(posedge clk);
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (slot_rd[s].ok && !done[s]) begin
                    done[s] = 1'b1;
                    slot_cs[s] <= 1'b0;
                end
            end
        end
        @(posedge clk);
        check_value("sdram_cmd count for priority", 32'(cmd_log.size() - base), 32'd4);
        for (int s = 0; s < NUM_SLOTS && base + s < cmd_log.size(); s++) begin
            check_value("sdram_cmd.addr priority order", 32'(cmd_log[base + s]),
                        32'(translate(offs[s], pa[s], WIDE_MAP[s])));
        end

        // new offsets from the host
        for (int s = 0; s < NUM_SLOTS; s++) begin
            rnd = xorshift32(rnd);
            write_offset(s, {2'b01, rnd[19:0]});
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            rnd = xorshift32(rnd);
            read_slot(s, rnd[15:0]);
            check_value("sdram_cmd.req count with offset", 32'(last_cmds), 32'd1);
            check_value("sdram_cmd.addr with offset", 32'(cmd_log[$]),
                        32'(translate(offs[s], rnd[15:0], WIDE_MAP[s])));
        end

        // download flushes caches and holds the arbiter
        rnd = xorshift32(rnd);
        read_slot(2, rnd[15:0]);
        downloading <= 1'b1;
        @(posedge clk);
        slot_cs[0]   <= 1'b1;  // a miss that has to wait out the download
        slot_addr[0] <= ~rnd[15:0];
        repeat (6) begin
            @(posedge clk);
            check_value("refresh_en in download", 32'(refresh_en), 32'd1);
            check_value("sdram_cmd.req in download", 32'(sdram_cmd.req), 32'd0);
        end
        slot_cs[0]  <= 1'b0;
        downloading <= 1'b0;
        n = 0;
        while (!ready && n < 20) begin
            @(posedge clk);
            n = n + 1;
        end
        check_value("ready delay", 32'(n), 32'd5);   // 4-cycle delay seen one edge later
        read_slot(2, rnd[15:0]);
        check_value("sdram_cmd.req count after download", 32'(last_cmds), 32'd1);
        for (int v = 0; v < 4; v++) begin
            vblank <= v[0];
            repeat (2) @(posedge clk);
            check_value("refresh_en idle", 32'(refresh_en), 32'(v[0]));
        end

        repeat (4) @(posedge clk);
        if (ok_checks == 0) begin
            errors = errors + 1;
            $display("no ok cycle was ever compared");
        end
        $display("errors: %0d, ok cycles checked: %0d", errors, ok_checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/sdram_model.sv
/*
 * SDRAM read responder
 * acks a command one cycle after it appears, then returns an
 * address-derived word after a random 2 to 5 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire sdram_pkg::sdram_cmd_t cmd,
    output logic                   sdram_ack,
    output logic                   data_rdy,
    output logic [31:0]            data_read
);

    logic                           busy;
    logic [sdram_pkg::SDRAM_AW-1:0] addr_q;
    logic [31:0]                    rnd;
    int                             cnt;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
            addr_q    <= '0;
            rnd       <= 32'd8;
            cnt       <= 0;
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            if (!busy && cmd.req) begin
                busy      <= 1'b1;
                sdram_ack <= 1'b1;
                addr_q    <= cmd.addr;
                rnd       <= xorshift32(rnd);
                cnt       <= 2 + int'(rnd[1:0]);   // 2 to 5 cycles
            end else if (busy) begin
                if (cnt == 1) begin
                    data_rdy  <= 1'b1;
                    data_read <= {addr_q[15:0] ^ 16'hA5C3, ~addr_q[15:0]};
                    busy      <= 1'b0;
                end
                cnt <= cnt - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- files.f
hw/sdram_pkg.sv
hw/rom_cfg_pkg.sv
hw/rom_cfg_regs.sv
hw/rom_slot.sv
hw/rom_arbiter.sv
hw/rom_mux_top.sv
dv/sdram_model.sv
dv/rom_mux_tb.sv

//--- hw/rom_arbiter.sv
/*
 * ROM read arbiter
 * fixed priority, slot 0 first, one SDRAM read in flight at a time;
 * lets refresh run in idle vertical blank and delays ready after loading
 */
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter #(
    parameter int NUM_SLOTS = 4
) (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire                                              downloading,
    input  wire                                              vblank,
    input  wire  [NUM_SLOTS-1:0]                             req,
    input  wire  [NUM_SLOTS-1:0][sdram_pkg::SDRAM_AW-1:0]    slot_addr,
    input  wire                                              sdram_ack,
    input  wire                                              data_rdy,
    output logic [NUM_SLOTS-1:0]                             grant,
    output sdram_pkg::sdram_cmd_t                            cmd,
    output logic                                             refresh_en,
    output logic                                             ready
);

    logic [NUM_SLOTS-1:0]           active;
    logic [NUM_SLOTS-1:0]           pick;
    logic [sdram_pkg::SDRAM_AW-1:0] pick_addr;
    logic [2:0]                     ready_sr;

    assign active = req & ~grant;   // skip the slot being served
    assign pick   = active & (~active + NUM_SLOTS'(1)); // lowest set bit wins

    always_comb begin
        pick_addr = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (pick[i]) begin
                pick_addr = slot_addr[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant      <= '0;
            cmd        <= '0;
            refresh_en <= 1'b1;
            ready      <= 1'b0;
            ready_sr   <= '0;
        end else if (downloading) begin
            grant      <= '0;
            cmd        <= '0;
            refresh_en <= 1'b1;
            ready      <= 1'b0;
            ready_sr   <= '0;
        end else begin
            {ready, ready_sr} <= {ready_sr, 1'b1};
            refresh_en <= 1'b0;
            if (sdram_ack) begin
                cmd.req <= 1'b0;
            end
            // next pick when idle or as the current read ends
            if (grant == '0 || data_rdy) begin
                grant      <= pick;
                cmd.req    <= |pick;
                refresh_en <= ~|pick & vblank;
                if (|pick) begin
                    cmd.addr <= pick_addr;
                end
            end
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(grant)
    );

    // a command always belongs to some slot
    a_req_granted: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd.req |-> (grant != '0)
    );

endmodule

`default_nettype wire

//--- hw/rom_cfg_pkg.sv
/*
 * ROM slot configuration types
 * host write port for the per-slot base offsets and the
 * data/ok pair that each slot hands back to its client
 */
`default_nettype none

package rom_cfg_pkg;

    localparam int SLOT_IW = 2;     // enough for 4 slots

    typedef struct packed {
        logic                           we;
        logic [SLOT_IW-1:0]             slot;
        logic [sdram_pkg::SDRAM_AW-1:0] offset;    // in 32-bit words
    } cfg_wr_t;

    typedef struct packed {
        logic        ok;
        logic [15:0] data;  // upper byte zero on 8-bit slots
    } slot_rd_t;

endpackage

`default_nettype wire

//--- hw/rom_cfg_regs.sv
/*
 * ROM slot offset registers
 * one base word offset per slot, loaded by the host at run time
 */
`timescale 1ns/1ps
`default_nettype none

module rom_cfg_regs #(
    parameter int NUM_SLOTS = 4
) (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire  rom_cfg_pkg::cfg_wr_t                       cfg_wr,
    output logic [NUM_SLOTS-1:0][sdram_pkg::SDRAM_AW-1:0]    offset
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            offset <= '0;   // all regions start at word 0
        end else if (cfg_wr.we) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (int'(cfg_wr.slot) == i) begin
                    offset[i] <= cfg_wr.offset;
                end
            end
        end
    end

    // writes to a slot that does not exist are lost
    a_slot_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_wr.we |-> (int'(cfg_wr.slot) < NUM_SLOTS)
    );

endmodule

`default_nettype wire

//--- hw/rom_mux_top.sv
/*
 * ROM access multiplexer
 * several read-only client slots sharing one 32-bit SDRAM read channel,
 * with run-time base offsets per slot
 */
`timescale 1ns/1ps
`default_nettype none

module rom_mux_top #(
    parameter int                   NUM_SLOTS = 4,
    parameter int                   SLOT_AW   = 16,
    parameter logic [NUM_SLOTS-1:0] SLOT_WIDE = '0  // 1 marks a 16-bit slot
) (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire                                      downloading,
    input  wire                                      vblank,
    input  wire  rom_cfg_pkg::cfg_wr_t               cfg_wr,
    input  wire  [NUM_SLOTS-1:0]                     slot_cs,
    input  wire  [NUM_SLOTS-1:0][SLOT_AW-1:0]        slot_addr,
    input  wire                                      sdram_ack,
    input  wire                                      data_rdy,
    input  wire  [31:0]                              data_read,
    output rom_cfg_pkg::slot_rd_t [NUM_SLOTS-1:0]    slot_rd,
    output sdram_pkg::sdram_cmd_t                    sdram_cmd,
    output logic                                     refresh_en,
    output logic                                     ready
);

    logic [NUM_SLOTS-1:0][sdram_pkg::SDRAM_AW-1:0] offset;
    logic [NUM_SLOTS-1:0][sdram_pkg::SDRAM_AW-1:0] word_addr;
    logic [NUM_SLOTS-1:0]                          req;
    logic [NUM_SLOTS-1:0]                          grant;

    rom_cfg_regs #(.NUM_SLOTS(NUM_SLOTS)) u_cfg_regs (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .cfg_wr ( cfg_wr ),
        .offset ( offset )
    );

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        rom_slot #(
            .SLOT_AW ( SLOT_AW      ),
            .WIDE    ( SLOT_WIDE[i] )
        ) u_slot (
            .clk       ( clk          ),
            .rst_n     ( rst_n        ),
            .flush     ( downloading  ),
            .cs        ( slot_cs[i]   ),
            .addr      ( slot_addr[i] ),
            .offset    ( offset[i]    ),
            .grant     ( grant[i]     ),
            .data_rdy  ( data_rdy     ),
            .din       ( data_read    ),  // same word to every slot
            .req       ( req[i]       ),
            .word_addr ( word_addr[i] ),
            .rd        ( slot_rd[i]   )
        );
    end

    rom_arbiter #(.NUM_SLOTS(NUM_SLOTS)) u_arbiter (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .vblank      ( vblank      ),
        .req         ( req         ),
        .slot_addr   ( word_addr   ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .grant       ( grant       ),
        .cmd         ( sdram_cmd   ),
        .refresh_en  ( refresh_en  ),
        .ready       ( ready       )
    );

endmodule

`default_nettype wire

//--- hw/rom_slot.sv
/*
 * ROM slot
 * turns a client byte/halfword address into an SDRAM word address,
 * keeps the last fetched word and asks the arbiter for a read on a miss
 */
`timescale 1ns/1ps
`default_nettype none

module rom_slot #(
    parameter int SLOT_AW = 16,
    parameter bit WIDE    = 1'b0    // 1 for 16-bit clients
) (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                flush,
    input  wire                                cs,
    input  wire  [SLOT_AW-1:0]                 addr,
    input  wire  [sdram_pkg::SDRAM_AW-1:0]     offset,
    input  wire                                grant,
    input  wire                                data_rdy,
    input  wire  sdram_pkg::sdram_word_u       din,
    output logic                               req,
    output logic [sdram_pkg::SDRAM_AW-1:0]     word_addr,
    output rom_cfg_pkg::slot_rd_t              rd
);

    localparam int AW = sdram_pkg::SDRAM_AW;

    logic [AW-1:0]          addr_ext;
    logic [AW-1:0]          trans_addr;
    logic [AW-1:0]          tag;        // word address of cache or pending read
    logic                   valid;
    sdram_pkg::sdram_word_u cache;
    sdram_pkg::sdram_word_u src;
    logic                   match;
    logic                   hit;
    logic                   fill;
    logic                   ok_q;
    logic [15:0]            dout_q;

    // lane select through the view that fits the slot width
    function automatic logic [15:0] pick_lane(sdram_pkg::sdram_word_u w, logic [1:0] sel);
        if (WIDE) begin
            return w.halves[sel[0]];
        end
        return {8'h00, w.bytes[sel]};
    endfunction

    assign addr_ext   = AW'(addr);
    assign trans_addr = offset + (WIDE ? (addr_ext >> 1) : (addr_ext >> 2));

    assign match = tag == trans_addr;
    assign hit   = valid && match;
    assign fill  = grant && data_rdy;   // our word is on the bus
    assign src   = fill ? din : cache;  // bypass so ok follows data_rdy by one cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            req   <= 1'b0;
            ok_q  <= 1'b0;
            tag   <= '0;
        end else if (flush) begin
            // ROM contents may change while downloading
            valid <= 1'b0;
            req   <= 1'b0;
            ok_q  <= 1'b0;
        end else begin
            ok_q <= cs && match && (valid || fill);
            if (fill) begin
                req   <= 1'b0;
                valid <= 1'b1;
            end else if (cs && !hit && !req) begin
                req   <= 1'b1;
                valid <= 1'b0;
                tag   <= trans_addr;    // address of the read in flight
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            cache <= din;
        end
        dout_q <= pick_lane(src, addr[1:0]);
    end

    assign word_addr = tag;
    assign rd.ok     = ok_q;
    assign rd.data   = dout_q;

    // a request only starts from a selected miss
    a_req_from_cs: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(req) |-> $past(cs)
    );

    // the arbiter only grants a slot that is asking
    a_grant_has_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        grant |-> req
    );

endmodule

`default_nettype wire

//--- hw/sdram_pkg.sv
/*
 * SDRAM read channel types
 * word address width, the read word with its byte and halfword views,
 * and the command that goes out to the SDRAM controller
 */
`default_nettype none

package sdram_pkg;

    localparam int SDRAM_AW = 22;   // 32-bit words, 16 MB reach

    // one read word, seen as bytes by 8-bit slots
    // and as halfwords by 16-bit slots
    typedef union packed {
        logic [3:0][7:0]  bytes;    // bytes[0] is bits 7:0
        logic [1:0][15:0] halves;   // halves[0] is bits 15:0
    } sdram_word_u;

    typedef struct packed {
        logic                req;   // held until the controller acks
        logic [SDRAM_AW-1:0] addr;  // word address
    } sdram_cmd_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the ROM mux testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module rom_mux_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vrom_mux_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
